// ==== ctrl_sequencer.f ====
+incdir+.
ctrl_seq_pkg.sv
reset_vector_seq.sv
instr_decoder.sv
exec_ctrl.sv
ctrl_sequencer.sv
tb_ctrl_sequencer.sv

// ==== tb_ctrl_sequencer.sv ====
`timescale 1ns/1ps
`include "ctrl_seq_macros.svh"

module tb_ctrl_sequencer import ctrl_seq_pkg::*; ();

    localparam instr_t EBREAK_INSTR = 32'h0010_0073;

    // One instruction and its expected responses
    typedef struct {
        string   name;
        instr_t  instr;
        flags_t  flags;
        int      cycles;     // ir_ld to ir_ld, no busy
        alu_op_t alu_op;     // first execute cycle
        logic    taken;
        int      rg_wr_n;
        int      mem_wr_n;
    } row_t;

    logic       clk_i;
    logic       reset_i;
    instr_t     ir_i;
    flags_t     flags_i;
    logic       mem_busy_i;
    ctrl_word_t ctrl_o;
    logic       ready_o;
    logic       halt_o;

    row_t rows[$];
    int   junk;

    ctrl_sequencer DUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ir_i       (ir_i),
        .flags_i    (flags_i),
        .mem_busy_i (mem_busy_i),
        .ctrl_o     (ctrl_o),
        .ready_o    (ready_o),
        .halt_o     (halt_o)
    );

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            report_fail($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            report_fail($sformatf("MISMATCH %s alu_op expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_fail($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // All nine active-low strobes high
    function automatic logic strobes_idle(input ctrl_word_t c);
        return c.ir_ld & c.pc_ld & c.pcp_ld & c.flags_ld & c.mem_wr &
               c.mem_rd & c.rg_wr & c.alu_ld & c.mdr_ld;
    endfunction

    // --------------------------------------------------
    // Reset and vector sequence
    // --------------------------------------------------
    task automatic apply_reset();
        reset_i = 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("reset strobes idle", 1'b1, strobes_idle(ctrl_o));
        check_bit("reset ready_o", 1'b0, ready_o);
        check_bit("reset halt_o", 1'b0, halt_o);
        @(posedge clk_i);
        #1;
        reset_i = 1'b1;
    endtask

    // Sample mid-cycle, then step to 1 ns past the next edge
    task automatic check_step(input string name, input ctrl_word_t exp, input logic exp_ready);
        @(negedge clk_i);
        check_ctrl(name, exp, ctrl_o);
        check_bit({name, " ready_o"}, exp_ready, ready_o);
        check_bit({name, " halt_o"}, 1'b0, halt_o);
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_vector_sequence();
        ctrl_word_t exp;
        exp = CTRL_IDLE;
        exp.rst_src = 1'b1;
        check_step("sync0", exp, 1'b0);
        // PC from reset vector
        exp.pc_ld  = 1'b0;
        exp.pc_src = PC_SRC_RESET_VEC;
        check_step("vector0", exp, 1'b0);
        exp.pc_ld  = 1'b1;
        exp.pc_src = PC_SRC_ALU_IMM;
        exp.mem_rd = 1'b0;
        check_step("vector1", exp, 1'b0);
        // PC from start address
        exp.mem_rd = 1'b1;
        exp.pc_ld  = 1'b0;
        exp.pc_src = PC_SRC_RESET_ADR;
        check_step("vector2", exp, 1'b0);
        exp.pc_ld  = 1'b1;
        exp.pc_src = PC_SRC_ALU_IMM;
        exp.mem_rd = 1'b0;
        check_step("vector3", exp, 1'b1);
        exp.rst_src = 1'b0;
        check_step("prefetch", exp, 1'b1);
    endtask

    // Fetch with busy cycles, entered 1 ns into Fetch
    task automatic fetch_first(input string name, input int busy);
        for (int i = 0; i < busy; i++) begin
            mem_busy_i = 1'b1;
            @(negedge clk_i);
            check_bit({name, " busy ir_ld"}, 1'b1, ctrl_o.ir_ld);
            check_bit({name, " busy mem_rd"}, 1'b0, ctrl_o.mem_rd);
            @(posedge clk_i);
            #1;
        end
        mem_busy_i = 1'b0;
        @(negedge clk_i);
        check_bit({name, " ir_ld"}, 1'b0, ctrl_o.ir_ld);
        @(posedge clk_i);
        #1;
    endtask

    // --------------------------------------------------
    // One table row, entered 1 ns into Decode
    // --------------------------------------------------
    task automatic run_row(input int r, input instr_t next_instr, input flags_t next_flags);
        int         k;
        int         busy;
        int         rg_n;
        int         mem_n;
        logic       done;
        ctrl_word_t dec_exp;
        k = 1;
        rg_n = 0;
        mem_n = 0;
        done = 1'b0;
        busy = $urandom % 4;
        // Decode loads PC + 4
        dec_exp = CTRL_IDLE;
        dec_exp.alu_ld = 1'b0;
        dec_exp.pc_ld = 1'b0;
        while (!done) begin
            // Stall the next Fetch where the timing rules put it
            mem_busy_i = (k >= rows[r].cycles) && (k < rows[r].cycles + busy);
            @(negedge clk_i);
            if (k == 1) begin
                check_ctrl({rows[r].name, " decode"}, dec_exp, ctrl_o);
            end
            if (k == 2) begin
                check_alu_op(rows[r].name, rows[r].alu_op, ctrl_o.alu_op);
                check_bit({rows[r].name, " halt_o"}, 1'b0, halt_o);
            end
            // Branch decision in the second execute cycle
            if (k == 3 && rows[r].instr[6:0] == `CS_OPC_BRANCH) begin
                check_bit({rows[r].name, " taken"}, rows[r].taken, !ctrl_o.pc_ld);
            end
            if (mem_busy_i) begin
                check_bit({rows[r].name, " busy ir_ld"}, 1'b1, ctrl_o.ir_ld);
                check_bit({rows[r].name, " busy mem_rd"}, 1'b0, ctrl_o.mem_rd);
            end
            if (!ctrl_o.rg_wr) rg_n++;
            if (!ctrl_o.mem_wr) mem_n++;
            if (!ctrl_o.ir_ld) begin
                done = 1'b1;
            end else if (k >= 40) begin
                report_fail({rows[r].name, ": no instruction load within 40 cycles"});
            end
            @(posedge clk_i);
            #1;
            if (!done) k++;
        end
        mem_busy_i = 1'b0;
        // IR and flags take the next row
        ir_i = next_instr;
        flags_i = next_flags;
        check_count({rows[r].name, " cycles"}, rows[r].cycles + busy, k);
        check_count({rows[r].name, " rg_wr pulses"}, rows[r].rg_wr_n, rg_n);
        check_count({rows[r].name, " mem_wr pulses"}, rows[r].mem_wr_n, mem_n);
    endtask

    // Ebreak from Decode on, then no more loads
    task automatic check_halt();
        @(posedge clk_i);
        #1;
        @(negedge clk_i);
        check_bit("ebreak halt_o", 1'b1, halt_o);
        check_bit("ebreak ready_o", 1'b0, ready_o);
        for (int i = 0; i < 20; i++) begin
            @(posedge clk_i);
            #1;
            @(negedge clk_i);
            check_bit("halted ir_ld", 1'b1, ctrl_o.ir_ld);
            check_bit("halted halt_o", 1'b1, halt_o);
            check_bit("halted ready_o", 1'b0, ready_o);
        end
        @(posedge clk_i);
        #1;
    endtask

    // Rows times 40 cycles plus margin
    initial begin
        #1;
        repeat (rows.size() * 40 + 200) @(posedge clk_i);
        report_fail("Watchdog expired before the test sequence completed");
    end

    // --------------------------------------------------
    // Stimulus table and run
    // --------------------------------------------------
    initial begin
        clk_i = 1'b0;
        reset_i = 1'b0;
        ir_i = 32'h0000_0013;
        flags_i = 4'h0;
        mem_busy_i = 1'b0;
        junk = $urandom(32'h68e7_f409);

        // ALU classes, rd x0 cases drop writeback
        rows.push_back(row_t'{"add x1", 32'h0031_00B3, 4'h0, 5, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"sub x0", 32'h4031_0033, 4'h0, 4, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"sra x5", 32'h4073_52B3, 4'h0, 5, 6'b101_010, 1'b0, 1, 0});
        rows.push_back(row_t'{"addi x4", 32'hFFF0_8213, 4'h0, 5, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"ori x3", 32'h8001_E193, 4'h0, 5, 6'b110_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"srai x2", 32'h4031_5113, 4'h0, 5, 6'b101_010, 1'b0, 1, 0});
        rows.push_back(row_t'{"slli x0", 32'h0020_9013, 4'h0, 4, 6'b001_000, 1'b0, 0, 0});
        // Memory
        rows.push_back(row_t'{"lw", 32'h0081_2303, 4'h0, 7, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"sw", 32'h0061_2623, 4'h0, 5, 6'b000_000, 1'b0, 0, 1});
        rows.push_back(row_t'{"sb", 32'h0061_01A3, 4'h0, 6, 6'b000_000, 1'b0, 0, 1});
        rows.push_back(row_t'{"sh", 32'h0061_1123, 4'h0, 6, 6'b000_000, 1'b0, 0, 1});
        // Branches, flags are {V, N, C, Z}
        rows.push_back(row_t'{"beq t", 32'h0020_8463, 4'b0001, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"beq n", 32'h0020_8463, 4'b0000, 5, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"bne t", 32'h0020_9463, 4'b0000, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"bne n", 32'h0020_9463, 4'b0001, 5, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"blt t", 32'h0020_C463, 4'b0100, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"blt n", 32'h0020_C463, 4'b1100, 5, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"bge t", 32'h0020_D463, 4'b1100, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"bge n", 32'h0020_D463, 4'b0100, 5, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"bltu t", 32'h0020_E463, 4'b0010, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"bltu n", 32'h0020_E463, 4'b0000, 5, 6'b000_010, 1'b0, 0, 0});
        rows.push_back(row_t'{"bgeu t", 32'h0020_F463, 4'b0000, 5, 6'b000_010, 1'b1, 0, 0});
        rows.push_back(row_t'{"bgeu n", 32'h0020_F463, 4'b0010, 5, 6'b000_010, 1'b0, 0, 0});
        // Jumps and upper immediates
        rows.push_back(row_t'{"jal x1", 32'h0100_00EF, 4'h0, 5, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"jal x0", 32'h0100_006F, 4'h0, 4, 6'b000_000, 1'b0, 0, 0});
        rows.push_back(row_t'{"jalr x1", 32'h0002_80E7, 4'h0, 5, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"jalr x0", 32'h0000_8067, 4'h0, 4, 6'b000_000, 1'b0, 0, 0});
        rows.push_back(row_t'{"lui x7", 32'h1234_53B7, 4'h0, 4, 6'b000_000, 1'b0, 1, 0});
        rows.push_back(row_t'{"auipc x8", 32'h0000_1417, 4'h0, 4, 6'b000_000, 1'b0, 1, 0});

        apply_reset();
        check_vector_sequence();
        fetch_first("fetch0", $urandom % 4);
        ir_i = rows[0].instr;
        flags_i = rows[0].flags;
        for (int r = 0; r < rows.size(); r++) begin
            if (r + 1 < rows.size()) begin
                run_row(r, rows[r + 1].instr, rows[r + 1].flags);
            end else begin
                run_row(r, EBREAK_INSTR, 4'h0);
            end
        end
        check_halt();

        // Second reset out of Halt
        apply_reset();
        check_vector_sequence();
        fetch_first("restart fetch", 0);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer import ctrl_seq_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  instr_t     ir_i,
    input  flags_t     flags_i,
    input  logic       mem_busy_i,
    output ctrl_word_t ctrl_o,
    output logic       ready_o,
    output logic       halt_o
);

    main_state_t main_state;
    main_state_t main_next;
    exec_state_t exec_state;

    // Sub-module outputs
    ctrl_word_t  vec_ctrl;
    logic        vec_done;
    exec_state_t first_exec;
    logic        rd_zero;
    logic        word_size;
    ctrl_word_t  exec_word;
    exec_state_t next_exec;
    logic        exec_done;
    logic        exec_halt;

    // Local words for the fixed states
    ctrl_word_t  prefetch_ctrl;
    ctrl_word_t  fetch_ctrl;
    ctrl_word_t  decode_ctrl;

    // --------------------------------------------------
    // Sub-sequences
    // --------------------------------------------------
    reset_vector_seq u_reset_vector_seq (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .active_i   (main_state == MS_RESET),
        .ctrl_o     (vec_ctrl),
        .vec_done_o (vec_done)
    );

    instr_decoder u_instr_decoder (
        .ir_i         (ir_i),
        .first_exec_o (first_exec),
        .rd_zero_o    (rd_zero),
        .word_size_o  (word_size)
    );

    exec_ctrl u_exec_ctrl (
        .exec_i      (exec_state),
        .ir_i        (ir_i),
        .flags_i     (flags_i),
        .rd_zero_i   (rd_zero),
        .word_size_i (word_size),
        .ctrl_o      (exec_word),
        .next_exec_o (next_exec),
        .exec_done_o (exec_done),
        .exec_halt_o (exec_halt)
    );

    // --------------------------------------------------
    // State registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            main_state <= MS_RESET;
            exec_state <= EX_LD;
        end else begin
            main_state <= main_next;
            // Decode picks the class, Execute walks its steps
            case (main_state)
                MS_DECODE:  exec_state <= first_exec;
                MS_EXECUTE: exec_state <= next_exec;
                default:    exec_state <= EX_LD;
            endcase
        end
    end

    // --------------------------------------------------
    // Main FSM next state
    // --------------------------------------------------
    always_comb begin
        case (main_state)
            MS_RESET:    main_next = vec_done ? MS_PREFETCH : MS_RESET;
            MS_PREFETCH: main_next = MS_FETCH;
            // Hold Fetch until memory returns the word
            MS_FETCH:    main_next = mem_busy_i ? MS_FETCH : MS_DECODE;
            MS_DECODE:   main_next = MS_EXECUTE;
            MS_EXECUTE: begin
                if (exec_halt) begin
                    main_next = MS_HALT;
                end else if (exec_done) begin
                    main_next = MS_PREFETCH;
                end else begin
                    main_next = MS_EXECUTE;
                end
            end
            // Only reset leaves Halt
            MS_HALT:     main_next = MS_HALT;
            default:     main_next = MS_RESET;
        endcase
    end

    // --------------------------------------------------
    // Fixed-state control words
    // --------------------------------------------------
    always_comb begin
        prefetch_ctrl = CTRL_IDLE;
        prefetch_ctrl.mem_rd = 1'b0;

        // Read held while busy, IR and PC prior load once data is there
        fetch_ctrl = CTRL_IDLE;
        fetch_ctrl.mem_rd = 1'b0;
        fetch_ctrl.ir_ld  = mem_busy_i;
        fetch_ctrl.pcp_ld = mem_busy_i;

        // Idle ALU setup is PC + 4, just load it
        decode_ctrl = CTRL_IDLE;
        decode_ctrl.alu_ld = 1'b0;
        decode_ctrl.pc_ld  = 1'b0;
        decode_ctrl.pc_src = PC_SRC_ALU_IMM;
    end

    // Output word by main state
    always_comb begin
        case (main_state)
            MS_RESET:    ctrl_o = vec_ctrl;
            MS_PREFETCH: ctrl_o = prefetch_ctrl;
            MS_FETCH:    ctrl_o = fetch_ctrl;
            MS_DECODE:   ctrl_o = decode_ctrl;
            MS_EXECUTE:  ctrl_o = exec_word;
            default:     ctrl_o = CTRL_IDLE;
        endcase
    end

    // --------------------------------------------------
    // Status
    // --------------------------------------------------

    // Halt shows from the ebreak execute cycle on
    assign halt_o = (main_state == MS_HALT) ||
                    ((main_state == MS_EXECUTE) && exec_halt);

    // Ready rises in VECTOR3 and drops on halt
    assign ready_o = (main_state == MS_RESET) ? vec_done : !halt_o;

endmodule

// ==== exec_ctrl.sv ====
`timescale 1ns/1ps
`include "ctrl_seq_macros.svh"

module exec_ctrl import ctrl_seq_pkg::*; (
    input  exec_state_t exec_i,
    input  instr_t      ir_i,
    input  flags_t      flags_i,
    input  logic        rd_zero_i,
    input  logic        word_size_i,
    output ctrl_word_t  ctrl_o,
    output exec_state_t next_exec_o,
    output logic        exec_done_o,
    output logic        exec_halt_o
);

    // Shift funct3 codes, these carry funct7 bits
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_SRL = 3'b101;

    // Branch funct3 codes
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    funct3_t    funct3;
    logic [2:0] funct7_up;
    alu_op_t    alu_op;
    logic       take_branch;

    assign funct3    = ir_i[14:12];
    assign funct7_up = ir_i[31:29];

    // --------------------------------------------------
    // ALU operation
    // --------------------------------------------------
    always_comb begin
        case (exec_i)
            EX_R: alu_op = {funct3, funct7_up};
            EX_I_ALU: begin
                // Only shifts keep funct7, srli vs srai
                if (funct3 == F3_SLL || funct3 == F3_SRL) begin
                    alu_op = {funct3, funct7_up};
                end else begin
                    alu_op = {funct3, 3'b000};
                end
            end
            // Compare by subtract
            EX_BR_FLAGS: alu_op = ALU_OP_SUB;
            default:     alu_op = ALU_OP_ADD;
        endcase
    end

    // --------------------------------------------------
    // Branch condition from loaded flags
    // --------------------------------------------------
    always_comb begin
        case (funct3)
            F3_BEQ:  take_branch = flags_i[`CS_FLAG_Z];
            F3_BNE:  take_branch = !flags_i[`CS_FLAG_Z];
            F3_BLT:  take_branch = flags_i[`CS_FLAG_N] ^ flags_i[`CS_FLAG_V];
            F3_BGE:  take_branch = (flags_i[`CS_FLAG_N] == flags_i[`CS_FLAG_V]);
            F3_BLTU: take_branch = flags_i[`CS_FLAG_C];
            F3_BGEU: take_branch = !flags_i[`CS_FLAG_C];
            default: take_branch = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Step controls
    // --------------------------------------------------
    always_comb begin
        ctrl_o = CTRL_IDLE;
        ctrl_o.alu_op = alu_op;
        next_exec_o = EX_LD;
        exec_done_o = 1'b0;
        exec_halt_o = 1'b0;
        case (exec_i)
            // Register-register ALU
            EX_R: begin
                ctrl_o.a_src  = A_SRC_RSA;
                ctrl_o.b_src  = B_SRC_RSB;
                ctrl_o.alu_ld = 1'b0;
                next_exec_o = EX_R_CMPL;
                // Nothing to write for x0
                exec_done_o = rd_zero_i;
            end
            EX_I_ALU: begin
                ctrl_o.a_src  = A_SRC_RSA;
                ctrl_o.b_src  = B_SRC_IMM;
                ctrl_o.alu_ld = 1'b0;
                next_exec_o = EX_I_ALU_CMPL;
                exec_done_o = rd_zero_i;
            end
            // ALU result to rd
            EX_R_CMPL, EX_I_ALU_CMPL: begin
                ctrl_o.wd_src = WD_SRC_ALU_OUT;
                ctrl_o.rg_wr  = 1'b0;
                exec_done_o = 1'b1;
            end

            // Load, address then read then MDR then writeback
            EX_LD: begin
                ctrl_o.a_src  = A_SRC_RSA;
                ctrl_o.b_src  = B_SRC_IMM;
                ctrl_o.alu_ld = 1'b0;
                next_exec_o = EX_LD_ACC;
            end
            EX_LD_ACC: begin
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mem_rd   = 1'b0;
                next_exec_o = EX_LD_MDR;
            end
            EX_LD_MDR: begin
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mdr_ld   = 1'b0;
                next_exec_o = EX_LD_CMPL;
            end
            EX_LD_CMPL: begin
                ctrl_o.wd_src = WD_SRC_MDR;
                ctrl_o.rg_wr  = 1'b0;
                exec_done_o = 1'b1;
            end

            // Store, sub-word reads the word first to merge
            EX_ST: begin
                ctrl_o.a_src  = A_SRC_RSA;
                ctrl_o.b_src  = B_SRC_IMM;
                ctrl_o.alu_ld = 1'b0;
                next_exec_o = word_size_i ? EX_ST_WRT : EX_ST_ACC;
            end
            EX_ST_ACC: begin
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mem_rd   = 1'b0;
                next_exec_o = EX_ST_WRT;
            end
            EX_ST_WRT: begin
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mem_wr   = 1'b0;
                exec_done_o = 1'b1;
            end

            // Branch, flags from rs1 - rs2, then target from PC prior
            EX_BR_FLAGS: begin
                ctrl_o.a_src    = A_SRC_RSA;
                ctrl_o.b_src    = B_SRC_RSB;
                ctrl_o.flags_ld = 1'b0;
                next_exec_o = EX_BR_DECIDE;
            end
            EX_BR_DECIDE: begin
                ctrl_o.a_src = A_SRC_PRIOR;
                ctrl_o.b_src = B_SRC_IMM;
                ctrl_o.pc_ld = !take_branch;
                exec_done_o = 1'b1;
            end

            // Jumps, PC first, link after
            EX_JAL: begin
                ctrl_o.a_src = A_SRC_PRIOR;
                ctrl_o.b_src = B_SRC_IMM;
                ctrl_o.pc_ld = 1'b0;
                next_exec_o = EX_JAL_RTR;
                exec_done_o = rd_zero_i;
            end
            EX_JALR: begin
                ctrl_o.a_src = A_SRC_RSA;
                ctrl_o.b_src = B_SRC_IMM;
                ctrl_o.pc_ld = 1'b0;
                next_exec_o = EX_JALR_RTR;
                exec_done_o = rd_zero_i;
            end
            // ALU register still holds PC + 4 from Decode
            EX_JAL_RTR, EX_JALR_RTR: begin
                ctrl_o.wd_src = WD_SRC_ALU_OUT;
                ctrl_o.rg_wr  = 1'b0;
                exec_done_o = 1'b1;
            end

            // Upper immediates
            EX_LUI: begin
                ctrl_o.wd_src = WD_SRC_IMM;
                ctrl_o.rg_wr  = 1'b0;
                exec_done_o = 1'b1;
            end
            EX_AUIPC: begin
                ctrl_o.a_src  = A_SRC_PRIOR;
                ctrl_o.b_src  = B_SRC_IMM;
                ctrl_o.alu_ld = 1'b0;
                ctrl_o.wd_src = WD_SRC_ALU_OUT;
                ctrl_o.rg_wr  = 1'b0;
                exec_done_o = 1'b1;
            end

            EX_EBREAK: begin
                exec_halt_o = 1'b1;
                exec_done_o = 1'b1;
            end
            default: exec_done_o = 1'b1;
        endcase
    end

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`include "ctrl_seq_macros.svh"

module instr_decoder import ctrl_seq_pkg::*; (
    input  instr_t      ir_i,
    output exec_state_t first_exec_o,
    output logic        rd_zero_o,
    output logic        word_size_o
);

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------
    logic [6:0]  opcode;
    logic [4:0]  rd;
    funct3_t     funct3;
    logic [11:0] funct12;

    assign opcode  = ir_i[6:0];
    assign rd      = ir_i[11:7];
    assign funct3  = ir_i[14:12];
    assign funct12 = ir_i[31:20];

    // --------------------------------------------------
    // Opcode to first execute step
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            `CS_OPC_RTYPE:  first_exec_o = EX_R;
            `CS_OPC_ITYPE:  first_exec_o = EX_I_ALU;
            `CS_OPC_LOAD:   first_exec_o = EX_LD;
            `CS_OPC_JALR:   first_exec_o = EX_JALR;
            `CS_OPC_STORE:  first_exec_o = EX_ST;
            `CS_OPC_BRANCH: first_exec_o = EX_BR_FLAGS;
            `CS_OPC_JAL:    first_exec_o = EX_JAL;
            `CS_OPC_LUI:    first_exec_o = EX_LUI;
            `CS_OPC_AUIPC:  first_exec_o = EX_AUIPC;
            `CS_OPC_SYSTEM: begin
                // Only ebreak is handled
                if (funct12 == `CS_F12_EBREAK) begin
                    first_exec_o = EX_EBREAK;
                end else begin
                    first_exec_o = EX_LD;
                end
            end
            // Unknown opcode runs as a load
            default: first_exec_o = EX_LD;
        endcase
    end

    // --------------------------------------------------
    // Shortcut flags for the execute steps
    // --------------------------------------------------

    // Write to x0 is dropped, no writeback step
    assign rd_zero_o = (rd == 5'd0);

    // Word store skips the read-merge step
    assign word_size_o = (funct3[1:0] == `CS_SIZE_WORD);

endmodule

// ==== reset_vector_seq.sv ====
`timescale 1ns/1ps

module reset_vector_seq import ctrl_seq_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       active_i,
    output ctrl_word_t ctrl_o,
    output logic       vec_done_o
);

    vector_state_t vec_state;
    vector_state_t vec_next;

    // --------------------------------------------------
    // Vector step register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            vec_state <= VS_SYNC0;
        end else if (!active_i) begin
            // Parked while the main FSM runs
            vec_state <= VS_SYNC0;
        end else begin
            vec_state <= vec_next;
        end
    end

    // --------------------------------------------------
    // Step controls
    // --------------------------------------------------
    always_comb begin
        ctrl_o = CTRL_IDLE;
        // Reset funct3 constant for the whole sequence
        ctrl_o.rst_src = 1'b1;
        vec_next = VS_SYNC0;
        case (vec_state)
            // Align VECTOR0 to the first edge after release
            VS_SYNC0: vec_next = VS_VECTOR0;
            VS_VECTOR0: begin
                // PC takes the reset vector constant
                ctrl_o.pc_ld = 1'b0;
                ctrl_o.pc_src = PC_SRC_RESET_VEC;
                vec_next = VS_VECTOR1;
            end
            VS_VECTOR1: begin
                // Read start address stored at the vector
                ctrl_o.mem_rd = 1'b0;
                vec_next = VS_VECTOR2;
            end
            VS_VECTOR2: begin
                // PC takes the start address from memory
                ctrl_o.pc_ld = 1'b0;
                ctrl_o.pc_src = PC_SRC_RESET_ADR;
                vec_next = VS_VECTOR3;
            end
            VS_VECTOR3: begin
                // First instruction read, main FSM moves on
                ctrl_o.mem_rd = 1'b0;
                vec_next = VS_SYNC0;
            end
            default: vec_next = VS_SYNC0;
        endcase
    end

    assign vec_done_o = (vec_state == VS_VECTOR3);

endmodule

// ==== ctrl_seq_pkg.sv ====
`include "ctrl_seq_macros.svh"

package ctrl_seq_pkg;

    // --------------------------------------------------
    // Plain vector types
    // --------------------------------------------------
    typedef logic [31:0] instr_t;
    typedef logic [3:0] flags_t;
    typedef logic [2:0] funct3_t;

    // Upper half is funct3, lower half is funct7[6:4]
    typedef logic [`CS_ALU_OP_W-1:0] alu_op_t;

    localparam alu_op_t ALU_OP_ADD = {3'b000, 3'b000};
    // Sub sets funct7 bit 5, which lands in the middle bit
    localparam alu_op_t ALU_OP_SUB = {3'b000, 3'b010};

    // --------------------------------------------------
    // Datapath mux selects
    // --------------------------------------------------
    typedef enum logic [`CS_A_SRC_W-1:0] {
        A_SRC_PC,
        A_SRC_RSA,
        A_SRC_PRIOR,
        A_SRC_ZERO
    } a_src_t;

    typedef enum logic [`CS_B_SRC_W-1:0] {
        B_SRC_FOUR,
        B_SRC_RSB,
        B_SRC_IMM
    } b_src_t;

    typedef enum logic [1:0] {
        PC_SRC_ALU_IMM,
        PC_SRC_RESET_VEC,
        PC_SRC_RESET_ADR
    } pc_src_t;

    typedef enum logic [1:0] {
        WD_SRC_IMM,
        WD_SRC_ALU_OUT,
        WD_SRC_MDR
    } wd_src_t;

    // --------------------------------------------------
    // State machines
    // --------------------------------------------------
    typedef enum logic [2:0] {
        MS_RESET,
        MS_PREFETCH,
        MS_FETCH,
        MS_DECODE,
        MS_EXECUTE,
        MS_HALT
    } main_state_t;

    typedef enum logic [2:0] {
        VS_SYNC0,
        VS_VECTOR0,
        VS_VECTOR1,
        VS_VECTOR2,
        VS_VECTOR3
    } vector_state_t;

    typedef enum logic [4:0] {
        EX_R, EX_R_CMPL,
        EX_I_ALU, EX_I_ALU_CMPL,
        EX_LD, EX_LD_ACC, EX_LD_MDR, EX_LD_CMPL,
        EX_JALR, EX_JALR_RTR,
        EX_ST, EX_ST_ACC, EX_ST_WRT,
        EX_BR_FLAGS, EX_BR_DECIDE,
        EX_JAL, EX_JAL_RTR,
        EX_LUI, EX_AUIPC,
        EX_EBREAK
    } exec_state_t;

    // --------------------------------------------------
    // Datapath control word, strobes are active low
    // --------------------------------------------------
    typedef struct packed {
        logic    ir_ld;
        logic    pc_ld;
        logic    pcp_ld;
        logic    flags_ld;
        logic    mem_wr;
        logic    mem_rd;
        logic    rg_wr;
        logic    alu_ld;
        logic    mdr_ld;
        logic    addr_src;   // 1 selects ALU out address
        logic    rst_src;    // 1 selects the reset funct3 constant
        pc_src_t pc_src;
        a_src_t  a_src;
        b_src_t  b_src;
        wd_src_t wd_src;
        alu_op_t alu_op;
    } ctrl_word_t;

    // All strobes off, ALU set up for PC + 4
    localparam ctrl_word_t CTRL_IDLE = '{
        ir_ld:    1'b1,
        pc_ld:    1'b1,
        pcp_ld:   1'b1,
        flags_ld: 1'b1,
        mem_wr:   1'b1,
        mem_rd:   1'b1,
        rg_wr:    1'b1,
        alu_ld:   1'b1,
        mdr_ld:   1'b1,
        addr_src: 1'b0,
        rst_src:  1'b0,
        pc_src:   PC_SRC_ALU_IMM,
        a_src:    A_SRC_PC,
        b_src:    B_SRC_FOUR,
        wd_src:   WD_SRC_IMM,
        alu_op:   ALU_OP_ADD
    };

endpackage

// ==== ctrl_seq_macros.svh ====
`ifndef CTRL_SEQ_MACROS_SVH
`define CTRL_SEQ_MACROS_SVH

// --------------------------------------------------
// RV32I major opcodes, bits [6:0]
// --------------------------------------------------
`define CS_OPC_RTYPE   7'b0110011
`define CS_OPC_ITYPE   7'b0010011
`define CS_OPC_LOAD    7'b0000011
`define CS_OPC_JALR    7'b1100111
`define CS_OPC_STORE   7'b0100011
`define CS_OPC_BRANCH  7'b1100011
`define CS_OPC_JAL     7'b1101111
`define CS_OPC_LUI     7'b0110111
`define CS_OPC_AUIPC   7'b0010111
`define CS_OPC_SYSTEM  7'b1110011

// --------------------------------------------------
// Flag bit positions, vector is {V, N, C, Z}
// --------------------------------------------------
`define CS_FLAG_Z  0
`define CS_FLAG_C  1
`define CS_FLAG_N  2
`define CS_FLAG_V  3

// Control field widths
`define CS_ALU_OP_W  6
`define CS_A_SRC_W   2
`define CS_B_SRC_W   2

// System funct12 for ebreak, ir[31:20]
`define CS_F12_EBREAK  12'h001

// Word access size, compared against funct3[1:0]
// Byte is 00, half is 01
`define CS_SIZE_WORD  2'b10

`endif
